// ==== sim.f ====
logic/analyzer_pkg.sv
logic/rstn_sync.sv
logic/bus_write_channel.sv
logic/bus_read_channel.sv
logic/analyzer_regs.sv
logic/trigger_unit.sv
logic/capture_store.sv
logic/analyzer_top.sv
verification/analyzer_tb.sv

// ==== Bender.yml ====
package:
  name: analyzer

sources:
  - logic/analyzer_pkg.sv
  - logic/rstn_sync.sv
  - logic/bus_write_channel.sv
  - logic/bus_read_channel.sv
  - logic/analyzer_regs.sv
  - logic/trigger_unit.sv
  - logic/capture_store.sv
  - logic/analyzer_top.sv
  - target: simulation
    files:
      - verification/analyzer_tb.sv

// ==== verification/analyzer_tb.sv ====
`timescale 1ns/100ps

module analyzer_tb;

    localparam int num_inputs      = 8;
    localparam int wave_addr_width = 4;
    localparam int wave_words      = 2 ** wave_addr_width;
    localparam int capture_len     = (32 / num_inputs) * wave_words;
    localparam int num_entries     = 26;
    localparam int cycle_limit     = 200 * num_entries + 4 * capture_len;

    localparam logic [1:0] bt_fixed  = analyzer_pkg::burst_fixed;
    localparam logic [1:0] bt_incr   = analyzer_pkg::burst_incr;
    localparam logic [1:0] rs_okay   = analyzer_pkg::resp_okay;
    localparam logic [1:0] rs_slverr = analyzer_pkg::resp_slverr;
    localparam logic [31:0] wave_at  = analyzer_pkg::wave_base;

    typedef enum logic [2:0] {
        k_write,
        k_read,
        k_poll,        // data masks the read word and exp_data is the value to wait for
        k_wave,        // a nonzero data masks the first byte against exp_data
        k_wave_stall
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [7:0]  len;
        logic [1:0]  burst;
        logic [1:0]  exp_resp;
        logic [31:0] exp_data;
    } entry_t;

    logic                     clk = 1'b0;
    logic                     rstn;
    logic [num_inputs-1:0]    digital_in;
    analyzer_pkg::bus_addr_t  aw, ar;
    analyzer_pkg::bus_wdata_t w;
    analyzer_pkg::bus_bresp_t b;
    analyzer_pkg::bus_rdata_t r;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;

    entry_t      tbl [num_entries];
    logic [31:0] beat_data [256];
    logic [1:0]  beat_resp [256];
    logic        beat_last [256];
    logic [31:0] ref_words [wave_words];
    integer      seed = 32'h8e26;
    int          cycle_count = 0;
    int          entry_errs = 0;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    analyzer_top #(
        .num_inputs(num_inputs), .wave_addr_width(wave_addr_width)
    ) i_analyzer_top (
        .clk(clk), .rstn(rstn), .digital_in(digital_in),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    always #50 clk = ~clk;

    // free running sample source
    always @(posedge clk) digital_in <= digital_in + 1'b1;

    task automatic flag_error(input string msg);
        $display("ERROR %0t ns: %s", $time, msg);
        error_count++;
        entry_errs++;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [7:0] len,
                             input logic [1:0] burst, output logic [1:0] resp,
                             output logic [3:0] id);
        int i;
        @(posedge clk);
        aw_valid <= 1'b1;
        aw       <= '{id: 4'h5, addr: addr, len: len, burst: burst};
        @(posedge clk);
        while (!aw_ready) @(posedge clk);
        aw_valid <= 1'b0;
        for (i = 0; i <= len; i++) begin
            w_valid <= 1'b1;
            w       <= '{data: data, strb: strb, last: (i == len)};
            @(posedge clk);
            while (!w_ready) @(posedge clk);
        end
        w_valid <= 1'b0;
        b_ready <= 1'b1;
        @(posedge clk);
        while (!b_valid) @(posedge clk);
        b_ready <= 1'b0;
        resp = b.resp;
        id   = b.id;
    endtask

    // one beat_data/resp/last entry per accepted r beat
    task automatic bus_read(input logic [31:0] addr, input logic [7:0] len,
                            input logic [1:0] burst, input logic stall);
        int n;
        n = 0;
        @(posedge clk);
        ar_valid <= 1'b1;
        ar       <= '{id: 4'h3, addr: addr, len: len, burst: burst};
        r_ready  <= stall ? 1'($random(seed)) : 1'b1;
        @(posedge clk);
        while (!ar_ready) @(posedge clk);
        ar_valid <= 1'b0;
        while (n <= len) begin
            @(posedge clk);
            if (r_valid && r_ready) begin
                if (r.id !== 4'h3) flag_error($sformatf("r id %h expected 3", r.id));
                beat_data[n] = r.data;
                beat_resp[n] = r.resp;
                beat_last[n] = r.last;
                n++;
            end
            if (stall) r_ready <= 1'($random(seed));
        end
        r_ready <= 1'b0;
    endtask

    task automatic check_read_beats(input entry_t e);
        int i;
        for (i = 0; i <= e.len; i++) begin
            if (beat_data[i] !== e.exp_data)
                flag_error($sformatf("read %h beat %0d data %h expected %h",
                                     e.addr, i, beat_data[i], e.exp_data));
            if (beat_resp[i] !== e.exp_resp)
                flag_error($sformatf("read %h beat %0d resp %b expected %b",
                                     e.addr, i, beat_resp[i], e.exp_resp));
            if (beat_last[i] !== (i == e.len))
                flag_error($sformatf("read %h beat %0d last %b", e.addr, i, beat_last[i]));
        end
    endtask

    // bytes count up across the whole memory with the earliest in the low byte
    task automatic check_wave(input entry_t e, input logic compare);
        int i;
        logic [7:0] cur, prev;
        prev = 8'd0;
        for (i = 0; i < wave_words * 4; i++) begin
            cur = beat_data[i / 4][8 * (i % 4) +: 8];
            if (i == 0 && e.data[7:0] != 8'd0 && (cur & e.data[7:0]) !== e.exp_data[7:0])
                flag_error($sformatf("first sample %h not %h under mask %h",
                                     cur, e.exp_data[7:0], e.data[7:0]));
            if (i > 0 && cur !== 8'(prev + 8'd1))
                flag_error($sformatf("sample %0d is %h after %h", i, cur, prev));
            prev = cur;
        end
        for (i = 0; i < wave_words; i++) begin
            if (beat_resp[i] !== rs_okay)
                flag_error($sformatf("wave beat %0d resp %b", i, beat_resp[i]));
            if (beat_last[i] !== (i == wave_words - 1))
                flag_error($sformatf("wave beat %0d last %b", i, beat_last[i]));
            if (compare && beat_data[i] !== ref_words[i])
                flag_error($sformatf("stalled beat %0d data %h expected %h",
                                     i, beat_data[i], ref_words[i]));
            if (!compare) ref_words[i] = beat_data[i];
        end
    endtask

    task automatic load_table();
        // reset values
        tbl[0]  = '{k_read,  32'h0000_0000, 32'h0, 4'hF, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[1]  = '{k_read,  32'h0000_0001, 32'h0, 4'hF, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[2]  = '{k_read,  32'h0000_0010, 32'h0, 4'hF, 8'd7, bt_incr, rs_okay, 32'h2};
        // mode and conditions with partial strobes
        tbl[3]  = '{k_write, 32'h0000_0001, 32'h3, 4'h1, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[4]  = '{k_write, 32'h0000_0001, 32'h1, 4'hE, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[5]  = '{k_write, 32'h0000_0010, 32'hC, 4'h1, 8'd3, bt_incr, rs_okay, 32'h0};
        tbl[6]  = '{k_write, 32'h0000_0014, 32'h5, 4'h2, 8'd1, bt_incr, rs_okay, 32'h0};
        tbl[7]  = '{k_read,  32'h0000_0001, 32'h0, 4'hF, 8'd0, bt_incr, rs_okay, 32'h3};
        tbl[8]  = '{k_read,  32'h0000_0010, 32'h0, 4'hF, 8'd3, bt_incr, rs_okay, 32'hC};
        tbl[9]  = '{k_read,  32'h0000_0014, 32'h0, 4'hF, 8'd3, bt_incr, rs_okay, 32'h2};
        tbl[10] = '{k_read,  32'h0000_0020, 32'h0, 4'hF, 8'd0, bt_incr, rs_okay, '1};
        // error paths
        tbl[11] = '{k_write, wave_at,       32'h55, 4'hF, 8'd0, bt_incr, rs_slverr, 32'h0};
        tbl[12] = '{k_write, 32'h0000_0010, 32'h0, 4'hF, 8'd1, 2'd2, rs_slverr, 32'h0};
        tbl[13] = '{k_read,  32'h0000_0010, 32'h0, 4'hF, 8'd0, bt_incr, rs_okay, 32'hC};
        tbl[14] = '{k_read,  32'h0000_0020, 32'h0, 4'hF, 8'd2, 2'd3, rs_slverr, '1};
        // forced capture
        tbl[15] = '{k_write, 32'h0000_0000, 32'h101, 4'h3, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[16] = '{k_poll,  32'h0000_0000, 32'h0101_0000, 4'hF, 8'd0, bt_incr, rs_okay,
                    32'h0100_0000};
        tbl[17] = '{k_wave,  wave_at, 32'h0, 4'hF, 8'd15, bt_incr, rs_okay, 32'h0};
        // rise on input 3, and mode
        tbl[18] = '{k_write, 32'h0000_0010, 32'h2, 4'h1, 8'd7, bt_incr, rs_okay, 32'h0};
        tbl[19] = '{k_write, 32'h0000_0013, 32'h3, 4'h1, 8'd0, bt_fixed, rs_okay, 32'h0};
        tbl[20] = '{k_write, 32'h0000_0001, 32'h0, 4'h1, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[21] = '{k_write, 32'h0000_0000, 32'h1, 4'h1, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[22] = '{k_poll,  32'h0000_0000, 32'h1, 4'hF, 8'd0, bt_incr, rs_okay, 32'h0};
        tbl[23] = '{k_poll,  32'h0000_0000, 32'h0101_0000, 4'hF, 8'd0, bt_incr, rs_okay,
                    32'h0100_0000};
        tbl[24] = '{k_wave,  wave_at, 32'hF, 4'hF, 8'd15, bt_incr, rs_okay, 32'h8};
        tbl[25] = '{k_wave_stall, wave_at, 32'hF, 4'hF, 8'd15, bt_incr, rs_okay, 32'h8};
    endtask

    // watchdog
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: no end of test after %0d cycles, the DUT stopped responding",
                 cycle_count);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int          idx;
        entry_t      e;
        logic [1:0]  resp;
        logic [3:0]  bid;

        rstn       = 1'b0;
        digital_in = '0;
        aw         = '0;
        aw_valid   = 1'b0;
        w          = '0;
        w_valid    = 1'b0;
        b_ready    = 1'b0;
        ar         = '0;
        ar_valid   = 1'b0;
        r_ready    = 1'b0;
        load_table();

        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) @(posedge clk);   // synchronizer plus one edge for the readies
        @(posedge clk);
        if (!aw_ready || !ar_ready || w_ready || b_valid || r_valid) begin
            flag_error($sformatf("after reset ready aw %b ar %b w %b valid b %b r %b",
                                 aw_ready, ar_ready, w_ready, b_valid, r_valid));
        end
        $display("reset check: %s", entry_errs == 0 ? "passed" : "failed");
        if (entry_errs == 0) tests_passed++;
        else tests_failed++;

        for (idx = 0; idx < num_entries; idx++) begin
            e          = tbl[idx];
            entry_errs = 0;
            case (e.kind)
                k_write: begin
                    bus_write(e.addr, e.data, e.strb, e.len, e.burst, resp, bid);
                    if (resp !== e.exp_resp)
                        flag_error($sformatf("write %h resp %b expected %b",
                                             e.addr, resp, e.exp_resp));
                    if (bid !== 4'h5) flag_error($sformatf("b id %h expected 5", bid));
                end
                k_read: begin
                    bus_read(e.addr, e.len, e.burst, 1'b0);
                    check_read_beats(e);
                end
                k_poll: begin
                    bus_read(e.addr, 8'd0, bt_incr, 1'b0);
                    while ((beat_data[0] & e.data) !== e.exp_data) begin
                        bus_read(e.addr, 8'd0, bt_incr, 1'b0);
                    end
                end
                k_wave: begin
                    bus_read(e.addr, e.len, e.burst, 1'b0);
                    check_wave(e, 1'b0);
                end
                default: begin
                    bus_read(e.addr, e.len, e.burst, 1'b1);
                    check_wave(e, 1'b1);
                end
            endcase
            $display("entry %0d %s at %h: %s", idx, e.kind.name(), e.addr,
                     entry_errs == 0 ? "passed" : "failed");
            if (entry_errs == 0) tests_passed++;
            else tests_failed++;
        end

        $display("summary: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/analyzer_top.sv ====
`timescale 1ns/100ps

module analyzer_top #(
    parameter int num_inputs      = 8,
    parameter int wave_addr_width = 12
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [num_inputs-1:0]     digital_in,
    input  analyzer_pkg::bus_addr_t   aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  analyzer_pkg::bus_wdata_t  w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output analyzer_pkg::bus_bresp_t  b,
    output logic                      b_valid,
    input  logic                      b_ready,
    input  analyzer_pkg::bus_addr_t   ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    output analyzer_pkg::bus_rdata_t  r,
    output logic                      r_valid,
    input  logic                      r_ready
);

    logic                                      analyzer_rstn_sync;
    analyzer_pkg::reg_write_t                  reg_wr;
    logic                                      reg_wr_valid;
    logic [31:0]                               rd_req_addr;
    logic                                      rd_req_valid;
    logic [31:0]                               rd_word;
    analyzer_pkg::chan_cond_t [num_inputs-1:0] conds;
    analyzer_pkg::global_mode_e                mode;
    logic                                      hit;
    logic                                      capture_start;
    logic                                      busy, done;
    logic [wave_addr_width-1:0]                wave_word_addr;
    logic [31:0]                               wave_word;

    rstn_sync i_rstn_sync (
        .clk(clk), .rstn(rstn), .rstn_sync(analyzer_rstn_sync)
    );

    bus_write_channel i_bus_write_channel (
        .clk(clk), .analyzer_rstn_sync(analyzer_rstn_sync),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .reg_wr(reg_wr), .reg_wr_valid(reg_wr_valid)
    );

    bus_read_channel i_bus_read_channel (
        .clk(clk), .analyzer_rstn_sync(analyzer_rstn_sync),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .rd_req_addr(rd_req_addr), .rd_req_valid(rd_req_valid), .rd_word(rd_word)
    );

    analyzer_regs #(
        .num_inputs(num_inputs), .wave_addr_width(wave_addr_width)
    ) i_analyzer_regs (
        .clk(clk), .analyzer_rstn_sync(analyzer_rstn_sync),
        .reg_wr(reg_wr), .reg_wr_valid(reg_wr_valid),
        .rd_req_addr(rd_req_addr), .rd_req_valid(rd_req_valid), .rd_word(rd_word),
        .conds(conds), .mode(mode), .hit(hit), .capture_start(capture_start),
        .busy(busy), .done(done),
        .wave_word_addr(wave_word_addr), .wave_word(wave_word)
    );

    trigger_unit #(
        .num_inputs(num_inputs)
    ) i_trigger_unit (
        .clk(clk), .analyzer_rstn_sync(analyzer_rstn_sync),
        .digital_in(digital_in), .conds(conds), .mode(mode), .hit(hit)
    );

    capture_store #(
        .num_inputs(num_inputs), .wave_addr_width(wave_addr_width)
    ) i_capture_store (
        .clk(clk), .analyzer_rstn_sync(analyzer_rstn_sync),
        .digital_in(digital_in), .capture_start(capture_start),
        .busy(busy), .done(done),
        .wave_word_addr(wave_word_addr), .wave_word(wave_word)
    );

endmodule

// ==== logic/capture_store.sv ====
`timescale 1ns/100ps

module capture_store #(
    parameter int num_inputs      = 8,
    parameter int wave_addr_width = 12
) (
    input  logic                        clk,
    input  logic                        analyzer_rstn_sync,
    input  logic [num_inputs-1:0]       digital_in,
    input  logic                        capture_start,
    output logic                        busy,
    output logic                        done,
    input  logic [wave_addr_width-1:0]  wave_word_addr,
    output logic [31:0]                 wave_word
);

    localparam int samples_per_word = 32 / num_inputs;
    localparam int slot_width       = (samples_per_word > 1) ? $clog2(samples_per_word) : 1;

    logic [31:0]                mem [2**wave_addr_width];
    logic [31:0]                pack_q, pack_next;
    logic [slot_width-1:0]      slot_q;
    logic [wave_addr_width-1:0] word_q;
    logic                       fin_q;       // last word written, one more busy cycle
    logic                       sampling;
    logic                       word_full;

    assign sampling  = capture_start || (busy && !fin_q);
    assign word_full = sampling && (slot_q == slot_width'(samples_per_word - 1));

    // new sample enters at the top, earliest ends in the low bits
    assign pack_next = (pack_q >> num_inputs) | (32'(digital_in) << (32 - num_inputs));

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            fin_q  <= 1'b0;
            slot_q <= '0;
            word_q <= '0;
        end else begin
            if (capture_start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end
            if (sampling) begin
                slot_q <= word_full ? '0 : slot_q + 1'b1;
            end
            if (word_full) begin
                word_q <= word_q + 1'b1;   // wraps back to 0 at the end
                fin_q  <= &word_q;
            end
            if (fin_q) begin
                fin_q <= 1'b0;
                busy  <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampling) begin
            pack_q <= pack_next;
        end
        if (word_full) begin
            mem[word_q] <= pack_next;
        end
        wave_word <= mem[wave_word_addr];
    end

endmodule

// ==== logic/trigger_unit.sv ====
`timescale 1ns/100ps

module trigger_unit #(
    parameter int num_inputs = 8
) (
    input  logic                                       clk,
    input  logic                                       analyzer_rstn_sync,
    input  logic [num_inputs-1:0]                      digital_in,
    input  analyzer_pkg::chan_cond_t [num_inputs-1:0]  conds,
    input  analyzer_pkg::global_mode_e                 mode,
    output logic                                       hit
);

    logic [num_inputs-1:0] prev_q;
    logic [num_inputs-1:0] match;

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            prev_q <= '0;
        end else begin
            prev_q <= digital_in;
        end
    end

    always_comb begin
        for (int i = 0; i < num_inputs; i++) begin
            case (conds[i].cond)
                analyzer_pkg::cond_logic0:    match[i] = !digital_in[i];
                analyzer_pkg::cond_logic1:    match[i] = digital_in[i];
                analyzer_pkg::cond_dont_care: match[i] = 1'b1;
                analyzer_pkg::cond_rise:      match[i] = digital_in[i] && !prev_q[i];
                analyzer_pkg::cond_fall:      match[i] = !digital_in[i] && prev_q[i];
                analyzer_pkg::cond_any_edge:  match[i] = digital_in[i] ^ prev_q[i];
                analyzer_pkg::cond_no_change: match[i] = digital_in[i] == prev_q[i];
                default:                      match[i] = 1'b0;
            endcase
            // invert does not revive the reserved code
            if (conds[i].cond != analyzer_pkg::cond_reserved) begin
                match[i] = match[i] ^ conds[i].invert;
            end
        end
    end

    always_comb begin
        case (mode)
            analyzer_pkg::mode_and:  hit = &match;
            analyzer_pkg::mode_or:   hit = |match;
            analyzer_pkg::mode_nand: hit = ~&match;
            default:                 hit = ~|match;
        endcase
    end

endmodule

// ==== logic/analyzer_regs.sv ====
`timescale 1ns/100ps

module analyzer_regs #(
    parameter int num_inputs      = 8,
    parameter int wave_addr_width = 12
) (
    input  logic                                       clk,
    input  logic                                       analyzer_rstn_sync,
    input  analyzer_pkg::reg_write_t                   reg_wr,
    input  logic                                       reg_wr_valid,
    input  logic [31:0]                                rd_req_addr,
    input  logic                                       rd_req_valid,
    output logic [31:0]                                rd_word,
    output analyzer_pkg::chan_cond_t [num_inputs-1:0]  conds,
    output analyzer_pkg::global_mode_e                 mode,
    input  logic                                       hit,
    output logic                                       capture_start,
    input  logic                                       busy,
    input  logic                                       done,
    output logic [wave_addr_width-1:0]                 wave_word_addr,
    input  logic [31:0]                                wave_word
);

    localparam analyzer_pkg::chan_cond_t cond_reset = '{
        invert: 1'b0,
        cond:   analyzer_pkg::cond_dont_care
    };

    logic        arm_q;
    logic        force_q;
    logic        done_clr_q;   // hides the old done once arm is written
    logic [31:0] wr_sel, rd_sel;
    logic [31:0] reg_rdata, reg_rdata_q;
    logic        wave_sel_q;

    assign wr_sel = reg_wr.addr - analyzer_pkg::addr_cond_base;
    assign rd_sel = rd_req_addr - analyzer_pkg::addr_cond_base;

    assign capture_start = arm_q && (hit || force_q) && !busy;

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            arm_q      <= 1'b0;
            force_q    <= 1'b0;
            done_clr_q <= 1'b0;
            mode       <= analyzer_pkg::mode_and;
            conds      <= {num_inputs{cond_reset}};
        end else begin
            if (capture_start) begin
                arm_q      <= 1'b0;
                force_q    <= 1'b0;   // one shot
                done_clr_q <= 1'b0;
            end
            if (reg_wr_valid) begin
                if (reg_wr.addr == analyzer_pkg::addr_ctrl) begin
                    if (reg_wr.strb[0]) begin
                        arm_q <= reg_wr.data[0];
                        if (reg_wr.data[0]) begin
                            done_clr_q <= 1'b1;
                        end
                    end
                    if (reg_wr.strb[1]) begin
                        force_q <= reg_wr.data[8];
                    end
                end
                if (reg_wr.addr == analyzer_pkg::addr_mode && reg_wr.strb[0]) begin
                    mode <= analyzer_pkg::global_mode_e'(reg_wr.data[1:0]);
                end
                // low byte only
                if (wr_sel < num_inputs && reg_wr.strb[0]) begin
                    conds[wr_sel] <= analyzer_pkg::chan_cond_t'(reg_wr.data[3:0]);
                end
            end
        end
    end

    always_comb begin
        reg_rdata = analyzer_pkg::unmapped_value;
        if (rd_req_addr == analyzer_pkg::addr_ctrl) begin
            reg_rdata = {7'd0, done && !done_clr_q, 7'd0, busy, 7'd0, force_q, 7'd0, arm_q};
        end else if (rd_req_addr == analyzer_pkg::addr_mode) begin
            reg_rdata = {30'd0, mode};
        end else if (rd_sel < num_inputs) begin
            reg_rdata = {28'd0, conds[rd_sel]};
        end
    end

    // both paths land one clock after the request
    always_ff @(posedge clk) begin
        if (rd_req_valid) begin
            reg_rdata_q <= reg_rdata;
            wave_sel_q  <= analyzer_pkg::is_wave(rd_req_addr);
        end
    end

    assign wave_word_addr = rd_req_addr[wave_addr_width-1:0];
    assign rd_word        = wave_sel_q ? wave_word : reg_rdata_q;

endmodule

// ==== logic/bus_read_channel.sv ====
`timescale 1ns/100ps

module bus_read_channel (
    input  logic                      clk,
    input  logic                      analyzer_rstn_sync,
    input  analyzer_pkg::bus_addr_t   ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    output analyzer_pkg::bus_rdata_t  r,
    output logic                      r_valid,
    input  logic                      r_ready,
    output logic [31:0]               rd_req_addr,
    output logic                      rd_req_valid,
    input  logic [31:0]               rd_word
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,    // address out to the register block
        st_wait,   // word comes back, catch it
        st_data    // beat offered on r
    } state_e;

    state_e      state_q, state_next;
    logic [3:0]  id_q;
    logic [31:0] addr_q;
    logic [7:0]  len_q;
    logic [1:0]  burst_q;
    logic [7:0]  beat_q;
    logic [31:0] hold_q;
    logic        ar_fire, r_fire, last;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign last    = (beat_q == len_q);

    always_comb begin
        state_next = state_q;
        case (state_q)
            st_idle: if (ar_fire) state_next = st_req;
            st_req:  state_next = st_wait;
            st_wait: state_next = st_data;
            st_data: if (r_fire) state_next = last ? st_idle : st_req;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            state_q  <= st_idle;
            ar_ready <= 1'b0;
            beat_q   <= 8'd0;
        end else begin
            state_q  <= state_next;
            ar_ready <= (state_next == st_idle);
            if (ar_fire) begin
                beat_q <= 8'd0;
            end else if (r_fire && !last) begin
                beat_q <= beat_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q    <= ar.id;
            addr_q  <= ar.addr;
            len_q   <= ar.len;
            burst_q <= ar.burst;
        end else if (r_fire && !last) begin
            addr_q <= addr_q + 32'd1;   // every accepted burst type steps
        end
        if (state_q == st_wait) begin
            hold_q <= rd_word;   // stays put while r is stalled
        end
    end

    assign rd_req_addr  = addr_q;
    assign rd_req_valid = (state_q == st_req);

    assign r_valid = (state_q == st_data);
    assign r       = '{id:   id_q,
                       data: hold_q,
                       resp: burst_q[1] ? analyzer_pkg::resp_slverr
                                        : analyzer_pkg::resp_okay,
                       last: last};

endmodule

// ==== logic/bus_write_channel.sv ====
`timescale 1ns/100ps

module bus_write_channel (
    input  logic                      clk,
    input  logic                      analyzer_rstn_sync,
    input  analyzer_pkg::bus_addr_t   aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  analyzer_pkg::bus_wdata_t  w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output analyzer_pkg::bus_bresp_t  b,
    output logic                      b_valid,
    input  logic                      b_ready,
    output analyzer_pkg::reg_write_t  reg_wr,
    output logic                      reg_wr_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_resp
    } state_e;

    state_e      state_q, state_next;
    logic [3:0]  id_q;
    logic [31:0] addr_q;
    logic [1:0]  burst_q;
    logic        err_q;
    logic        beat_err;
    logic        aw_fire, w_fire;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    always_comb begin
        state_next = state_q;
        case (state_q)
            st_idle: if (aw_fire) state_next = st_data;
            st_data: if (w_fire && w.last) state_next = st_resp;
            st_resp: if (b_ready) state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            state_q  <= st_idle;
            aw_ready <= 1'b0;   // rises on the first edge after release
            err_q    <= 1'b0;
        end else begin
            state_q  <= state_next;
            aw_ready <= (state_next == st_idle);
            if (aw_fire) begin
                err_q <= aw.burst[1];   // bursts 2 and 3
            end else if (w_fire) begin
                err_q <= beat_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q    <= aw.id;
            addr_q  <= aw.addr;
            burst_q <= aw.burst;
        end else if (w_fire && burst_q == analyzer_pkg::burst_incr) begin
            addr_q <= addr_q + 32'd1;
        end
    end

    // sticky, once a beat is bad the rest of the burst is dropped
    assign beat_err = err_q || analyzer_pkg::is_wave(addr_q);

    assign w_ready      = (state_q == st_data);
    assign reg_wr_valid = w_fire && !beat_err;
    assign reg_wr       = '{addr: addr_q, data: w.data, strb: w.strb};

    assign b_valid = (state_q == st_resp);
    assign b       = '{id: id_q,
                       resp: err_q ? analyzer_pkg::resp_slverr : analyzer_pkg::resp_okay};

endmodule

// ==== logic/rstn_sync.sv ====
`timescale 1ns/100ps

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic rstn_sync
);

    logic meta_q;

    // assert at once, release after two edges
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            meta_q    <= 1'b0;
            rstn_sync <= 1'b0;
        end else begin
            meta_q    <= 1'b1;
            rstn_sync <= meta_q;
        end
    end

endmodule

// ==== logic/analyzer_pkg.sv ====
package analyzer_pkg;

    // address channel request, shared by aw and ar
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  burst;
    } bus_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } bus_wdata_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } bus_bresp_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } bus_rdata_t;

    // one register update, word addressed
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } reg_write_t;

    typedef enum logic [2:0] {
        cond_logic0    = 3'd0,
        cond_logic1    = 3'd1,
        cond_dont_care = 3'd2,
        cond_rise      = 3'd3,
        cond_fall      = 3'd4,
        cond_any_edge  = 3'd5,
        cond_no_change = 3'd6,
        cond_reserved  = 3'd7   // never matches
    } cond_e;

    typedef struct packed {
        logic  invert;
        cond_e cond;
    } chan_cond_t;

    typedef enum logic [1:0] {
        mode_and  = 2'd0,
        mode_or   = 2'd1,
        mode_nand = 2'd2,
        mode_nor  = 2'd3
    } global_mode_e;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    localparam logic [1:0] burst_fixed = 2'd0;
    localparam logic [1:0] burst_incr  = 2'd1;

    localparam logic [31:0] addr_ctrl      = 32'h0000_0000;
    localparam logic [31:0] addr_mode      = 32'h0000_0001;
    localparam logic [31:0] addr_cond_base = 32'h0000_0010;
    localparam logic [31:0] wave_base      = 32'h0100_0000;
    localparam logic [31:0] unmapped_value = 32'hFFFF_FFFF;

    // wave region is 0x0100_0000 .. 0x01FF_FFFF
    function automatic logic is_wave(input logic [31:0] addr);
        return (addr & 32'hFF00_0000) == wave_base;
    endfunction

endpackage
